// ==== hw/mem_line_pkg.sv ====
package mem_line_pkg;

   ////////////////////
   // widths
   ////////////////////

   // one controller data word.
   localparam int beat_w = 128;
   // a cache line spans two beats.
   localparam int line_w = 2 * beat_w;
   // cache line address.
   localparam int addr_w = 25;
   // controller address, column granular.
   localparam int app_addr_w = 31;

   ////////////////////
   // controller codes
   ////////////////////

   // only write and read are ever issued.
   typedef enum logic [2:0] {
      app_write = 3'b000,
      app_read  = 3'b001
   } app_cmd_e;

   ////////////////////
   // payloads
   ////////////////////

   // cache request, 282 bits.
   typedef struct packed {
      logic              write;
      logic [addr_w-1:0] addr;
      logic [line_w-1:0] data;
   } line_req_t;

   // read response back to the cache.
   typedef struct packed {
      logic [line_w-1:0] data;
   } line_rsp_t;

   // address fifo entry, 34 bits.
   typedef struct packed {
      app_cmd_e              cmd;
      logic [app_addr_w-1:0] addr;
   } app_cmd_t;

   // one write data fifo beat.
   typedef struct packed {
      logic [beat_w-1:0] data;
   } app_wdf_t;

   // a line is one burst of four columns, two beats.
   // so the controller address is the line address times four.
   function automatic logic [app_addr_w-1:0] app_addr_of(
      input logic [addr_w-1:0] line_addr
   );
      return app_addr_w'({line_addr, 2'b00});
   endfunction

endpackage

// ==== hw/line_req_intake.sv ====
`timescale 1ns/1ps

module line_req_intake
   import mem_line_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      init_done,

   // cache request channel.
   input  logic      req_valid,
   input  line_req_t req,
   output logic      req_ready,

   // toward the sequencer.
   output logic      hold_valid,
   output line_req_t hold,
   input  logic      hold_ready
);

   logic take;
   logic drain;

   ////////////////////
   // handshakes
   ////////////////////

   // open only with the controller up and the slot empty.
   // ready never looks at hold_ready, so no comb path to the sequencer.
   assign req_ready = init_done && !hold_valid;

   assign take = req_valid && req_ready;

   // sequencer done with the held request.
   assign drain = hold_valid && hold_ready;

   ////////////////////
   // holding register
   ////////////////////

   // slot occupancy.
   always_ff @(posedge clk) begin
      if (reset) begin
         hold_valid <= 1'b0;
      end else if (take) begin
         hold_valid <= 1'b1;
      end else if (drain) begin
         hold_valid <= 1'b0;
      end
   end

   // payload, loaded on accept only.
   always_ff @(posedge clk) begin
      if (take) begin
         hold <= req;
      end
   end

   ////////////////////
   // checks
   ////////////////////

   // cache keeps its request steady while it waits.
   // this covers the whole pre-init stretch as well.
   req_stable_a : assert property (
      @(posedge clk) disable iff (reset)
      req_valid && !req_ready |=> req_valid && $stable(req)
   ) else $error("req changed while waiting for req_ready");

endmodule

// ==== hw/beat_sequencer.sv ====
`timescale 1ns/1ps

module beat_sequencer
   import mem_line_pkg::*;
#(
   parameter int read_timeout_cycles = 64
) (
   input  logic      clk,
   input  logic      reset,

   // held request from the intake.
   input  logic      hold_valid,
   input  line_req_t hold,
   output logic      hold_ready,

   // controller flow control.
   input  logic      af_afull,
   input  logic      wdf_afull,

   // assembler still owns a line.
   input  logic      line_busy,

   // controller fifos.
   output logic      af_wren,
   output app_cmd_t  af,
   output logic      wdf_wren,
   output app_wdf_t  wdf,

   // one pulse per read command.
   output logic      read_issued
);

   typedef enum logic [1:0] {
      st_idle,
      st_wr_beat0,
      st_wr_beat1,
      st_rd_cmd
   } state_e;

   localparam int wait_w = $clog2(read_timeout_cycles + 1);

   state_e            state;
   state_e            state_next;
   logic              fifo_room;
   logic              wr0_go;
   logic              wr1_go;
   logic              rd_go;
   logic [wait_w-1:0] read_wait;

   ////////////////////
   // go conditions
   ////////////////////

   // nothing moves while either fifo is almost full.
   assign fifo_room = !af_afull && !wdf_afull;

   // command plus lower beat.
   assign wr0_go = (state == st_wr_beat0) && fifo_room;
   // upper beat.
   assign wr1_go = (state == st_wr_beat1) && fifo_room;
   // a read also needs the assembler free.
   assign rd_go  = (state == st_rd_cmd) && fifo_room && !line_busy;

   ////////////////////
   // fsm
   ////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= st_idle;
      end else begin
         state <= state_next;
      end
   end

   always_comb begin
      state_next = state;
      case (state)
         st_idle: begin
            if (hold_valid) begin
               state_next = hold.write ? st_wr_beat0 : st_rd_cmd;
            end
         end
         st_wr_beat0: begin
            if (wr0_go) begin
               state_next = st_wr_beat1;
            end
         end
         st_wr_beat1: begin
            if (wr1_go) begin
               state_next = st_idle;
            end
         end
         st_rd_cmd: begin
            if (rd_go) begin
               state_next = st_idle;
            end
         end
         default: begin
            state_next = st_idle;
         end
      endcase
   end

   ////////////////////
   // outputs
   ////////////////////

   assign af_wren     = wr0_go || rd_go;
   assign wdf_wren    = wr0_go || wr1_go;
   assign read_issued = rd_go;

   // release on the last beat or the read command.
   assign hold_ready  = wr1_go || rd_go;

   // command and address straight off the held request.
   // beat 0 is the lower half, beat 1 the upper.
   always_comb begin
      af.cmd  = hold.write ? app_write : app_read;
      af.addr = app_addr_of(hold.addr);
      if (state == st_wr_beat1) begin
         wdf.data = hold.data[line_w-1:beat_w];
      end else begin
         wdf.data = hold.data[beat_w-1:0];
      end
   end

   ////////////////////
   // read watchdog
   ////////////////////

   // cycles spent with a read outstanding, saturating.
   always_ff @(posedge clk) begin
      if (reset || read_issued || !line_busy) begin
         read_wait <= '0;
      end else if (read_wait != wait_w'(read_timeout_cycles)) begin
         read_wait <= read_wait + 1'b1;
      end
   end

   ////////////////////
   // checks
   ////////////////////

   // beats only while the intake still holds a write.
   wdf_in_write_a : assert property (
      @(posedge clk) disable iff (reset)
      wdf_wren |-> hold_valid && hold.write
   ) else $error("wdf_wren without a write in progress");

   // the assembler must give the line back in time.
   read_timeout_a : assert property (
      @(posedge clk) disable iff (reset)
      line_busy |-> read_wait < wait_w'(read_timeout_cycles)
   ) else $error("read not completed within read_timeout_cycles");

endmodule

// ==== hw/read_line_assembler.sv ====
`timescale 1ns/1ps

module read_line_assembler
   import mem_line_pkg::*;
(
   input  logic              clk,
   input  logic              reset,

   // from the sequencer.
   input  logic              read_issued,

   // controller read path, never stalls.
   input  logic              rd_data_valid,
   input  logic [beat_w-1:0] rd_data,

   // cache response channel.
   output logic              rsp_valid,
   output line_rsp_t         rsp,
   input  logic              rsp_ready,

   output logic              line_busy
);

   logic              got_low;
   logic [beat_w-1:0] low_half;
   logic              rsp_taken;
   logic              last_beat;

   assign rsp_taken = rsp_valid && rsp_ready;

   // second beat of the pair.
   assign last_beat = rd_data_valid && got_low;

   ////////////////////
   // control
   ////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         got_low   <= 1'b0;
         rsp_valid <= 1'b0;
         line_busy <= 1'b0;
      end else begin
         // busy from the command until the cache has the line.
         if (read_issued) begin
            line_busy <= 1'b1;
         end else if (rsp_taken) begin
            line_busy <= 1'b0;
         end
         // beat counter, one bit is enough.
         if (rd_data_valid) begin
            got_low <= !got_low;
         end
         // line goes out the cycle after the upper beat.
         if (last_beat) begin
            rsp_valid <= 1'b1;
         end else if (rsp_taken) begin
            rsp_valid <= 1'b0;
         end
      end
   end

   ////////////////////
   // data
   ////////////////////

   // lower half parked, line built on the upper half.
   always_ff @(posedge clk) begin
      if (rd_data_valid && !got_low) begin
         low_half <= rd_data;
      end
      if (last_beat) begin
         rsp.data <= {rd_data, low_half};
      end
   end

   ////////////////////
   // checks
   ////////////////////

   // beats only for the read the sequencer issued.
   no_stray_beat_a : assert property (
      @(posedge clk) disable iff (reset)
      rd_data_valid |-> line_busy && !rsp_valid
   ) else $error("rd_data_valid with no read outstanding");

endmodule

// ==== hw/mem_line_port.sv ====
`timescale 1ns/1ps

module mem_line_port
   import mem_line_pkg::*;
#(
   parameter int read_timeout_cycles = 64
) (
   input  logic              clk,
   input  logic              reset,

   // cache side.
   input  logic              req_valid,
   input  line_req_t         req,
   output logic              req_ready,
   output logic              rsp_valid,
   output line_rsp_t         rsp,
   input  logic              rsp_ready,

   // controller side.
   input  logic              init_done,
   output logic              af_wren,
   output app_cmd_t          af,
   input  logic              af_afull,
   output logic              wdf_wren,
   output app_wdf_t          wdf,
   input  logic              wdf_afull,
   input  logic              rd_data_valid,
   input  logic [beat_w-1:0] rd_data
);

   logic      hold_valid;
   line_req_t hold;
   logic      hold_ready;
   logic      line_busy;
   logic      read_issued;

   ////////////////////
   // request path
   ////////////////////

   line_req_intake u_intake (
      .clk        (clk),
      .reset      (reset),
      .init_done  (init_done),
      .req_valid  (req_valid),
      .req        (req),
      .req_ready  (req_ready),
      .hold_valid (hold_valid),
      .hold       (hold),
      .hold_ready (hold_ready)
   );

   beat_sequencer #(
      .read_timeout_cycles (read_timeout_cycles)
   ) u_sequencer (
      .clk         (clk),
      .reset       (reset),
      .hold_valid  (hold_valid),
      .hold        (hold),
      .hold_ready  (hold_ready),
      .af_afull    (af_afull),
      .wdf_afull   (wdf_afull),
      .line_busy   (line_busy),
      .af_wren     (af_wren),
      .af          (af),
      .wdf_wren    (wdf_wren),
      .wdf         (wdf),
      .read_issued (read_issued)
   );

   ////////////////////
   // response path
   ////////////////////

   read_line_assembler u_assembler (
      .clk           (clk),
      .reset         (reset),
      .read_issued   (read_issued),
      .rd_data_valid (rd_data_valid),
      .rd_data       (rd_data),
      .rsp_valid     (rsp_valid),
      .rsp           (rsp),
      .rsp_ready     (rsp_ready),
      .line_busy     (line_busy)
   );

endmodule

// ==== dv/app_mem_model.sv ====
`timescale 1ns/1ps

module app_mem_model
   import mem_line_pkg::*;
#(
   parameter int          read_latency = 4,
   parameter int          init_cycles  = 30,
   parameter logic [31:0] seed         = 32'h4bc5_c0be
) (
   input  logic              clk,
   input  logic              reset,
   input  logic              af_wren,
   input  app_cmd_t          af,
   input  logic              wdf_wren,
   input  app_wdf_t          wdf,
   output logic              init_done,
   output logic              af_afull,
   output logic              wdf_afull,
   output logic              rd_data_valid,
   output logic [beat_w-1:0] rd_data
);

   // beats by controller address, two columns apart.
   logic [beat_w-1:0]     mem [logic [app_addr_w-1:0]];
   logic [31:0]           lfsr = seed;
   logic                  in_reset = 1'b1;
   int                    cycle = 0;
   int                    init_count = 0;
   logic                  rd_pending = 1'b0;
   int                    rd_at = 0;
   logic [app_addr_w-1:0] rd_base = '0;
   logic [app_addr_w-1:0] wr_base = '0;
   int                    wr_beat = 0;

   // galois form, right shift.
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic take_bit(output logic b);
      b = lfsr[0];
      lfsr = lfsr_step(lfsr);
   endtask

   // unwritten columns read back a pattern of the whole address.
   function automatic logic [beat_w-1:0] read_beat(input logic [app_addr_w-1:0] a);
      if (mem.exists(a)) begin
         return mem[a];
      end
      return {4{32'(a) ^ 32'h5a5a_c3c3}};
   endfunction

   initial begin
      init_done     = 1'b0;
      af_afull      = 1'b0;
      wdf_afull     = 1'b0;
      rd_data_valid = 1'b0;
      rd_data       = '0;
   end

   ////////////////////
   // fifo side
   ////////////////////

   // commands and beats sampled on the rising edge.
   always @(posedge clk) begin
      in_reset = reset;
      if (reset) begin
         cycle      = 0;
         init_count = 0;
         rd_pending = 1'b0;
      end else begin
         cycle++;
         if (init_count < init_cycles) begin
            init_count++;
         end
         if (af_wren && af.cmd == app_read) begin
            rd_pending = 1'b1;
            rd_at      = cycle;
            rd_base    = af.addr;
         end
         // beat 0 always travels with its command.
         if (wdf_wren) begin
            if (af_wren) begin
               wr_base = af.addr;
               wr_beat = 0;
            end
            mem[wr_base + app_addr_w'(2 * wr_beat)] = wdf.data;
            wr_beat++;
         end
      end
   end

   ////////////////////
   // driven outputs
   ////////////////////

   // everything toward the dut changes on the falling edge.
   always @(negedge clk) begin
      logic b0;
      logic b1;
      logic b2;
      logic b3;
      take_bit(b0);
      take_bit(b1);
      take_bit(b2);
      take_bit(b3);
      rd_data_valid = 1'b0;
      if (in_reset) begin
         init_done = 1'b0;
         af_afull  = 1'b0;
         wdf_afull = 1'b0;
      end else begin
         init_done = (init_count >= init_cycles);
         // each flag set about one cycle in four.
         af_afull  = b0 && b1;
         wdf_afull = b2 && b3;
         // lower beat, then upper beat the cycle after.
         if (rd_pending && cycle == rd_at + read_latency - 1) begin
            rd_data_valid = 1'b1;
            rd_data       = read_beat(rd_base);
         end else if (rd_pending && cycle == rd_at + read_latency) begin
            rd_data_valid = 1'b1;
            rd_data       = read_beat(rd_base + app_addr_w'(2));
         end
      end
   end

endmodule

// ==== dv/tb_mem_line_port.sv ====
`timescale 1ns/1ps

module tb_mem_line_port
   import mem_line_pkg::*;
();

   typedef struct packed {
      logic              write;
      logic [addr_w-1:0] addr;
      logic [31:0]       seed;
   } stim_t;

   localparam int n_tests = 24;
   // forty cycles per entry plus reset and controller init.
   localparam int cycle_limit = n_tests * 40 + 16 + 30;

   // write flag, line address, data seed.
   stim_t stim_table [n_tests] = '{
      '{1'b1, 25'h0000010, 32'h0000_00a1}, '{1'b1, 25'h0000011, 32'h1357_9bdf},
      // the second of two back to back reads waits on line_busy.
      '{1'b0, 25'h0000010, 32'h0000_0000}, '{1'b0, 25'h0000011, 32'h0000_0000},
      '{1'b1, 25'h1ffffff, 32'hffff_0000}, '{1'b0, 25'h1ffffff, 32'h0000_0000},
      // overwrite, then read twice.
      '{1'b1, 25'h0000010, 32'hdead_0001}, '{1'b0, 25'h0000010, 32'h0000_0000},
      '{1'b0, 25'h0000010, 32'h0000_0000}, '{1'b1, 25'h0abcdef, 32'h0f0f_0f0f},
      '{1'b1, 25'h1234567, 32'h8642_0000}, '{1'b0, 25'h0abcdef, 32'h0000_0000},
      '{1'b0, 25'h1234567, 32'h0000_0000}, '{1'b1, 25'h0000000, 32'h7777_1234},
      '{1'b0, 25'h0000000, 32'h0000_0000}, '{1'b1, 25'h1555555, 32'haaaa_5555},
      '{1'b1, 25'h0aaaaaa, 32'h5555_aaaa}, '{1'b0, 25'h0aaaaaa, 32'h0000_0000},
      '{1'b0, 25'h1555555, 32'h0000_0000}, '{1'b1, 25'h0000011, 32'hc0de_0042},
      '{1'b0, 25'h0000011, 32'h0000_0000}, '{1'b0, 25'h1ffffff, 32'h0000_0000},
      '{1'b0, 25'h0abcdef, 32'h0000_0000}, '{1'b0, 25'h0000010, 32'h0000_0000}
   };

   logic              clk = 1'b0;
   logic              reset;
   logic              req_valid;
   line_req_t         req;
   logic              req_ready;
   logic              rsp_valid;
   line_rsp_t         rsp;
   logic              rsp_ready;
   logic              init_done;
   logic              af_wren;
   app_cmd_t          af;
   logic              af_afull;
   logic              wdf_wren;
   app_wdf_t          wdf;
   logic              wdf_afull;
   logic              rd_data_valid;
   logic [beat_w-1:0] rd_data;

   logic [31:0]       lfsr = 32'h4bc5_c0be;
   logic [line_w-1:0] line_data [n_tests];
   // predicted memory contents by line address.
   logic [line_w-1:0] pred [logic [addr_w-1:0]];
   // expected traffic in issue order, each tagged with its entry.
   app_cmd_t          cmd_q [$];
   int                cmd_idx_q [$];
   app_wdf_t          beat_q [$];
   int                beat_idx_q [$];
   line_rsp_t         line_q [$];
   int                line_idx_q [$];
   bit                entry_bad [n_tests];
   int                errors = 0;
   int                done_count = 0;
   int                cycle = 0;
   logic              line_out = 1'b0;
   logic              rsp_held = 1'b0;
   line_rsp_t         rsp_prev;

   mem_line_port #(
      .read_timeout_cycles (64)
   ) DUT (
      .clk           (clk),
      .reset         (reset),
      .req_valid     (req_valid),
      .req           (req),
      .req_ready     (req_ready),
      .rsp_valid     (rsp_valid),
      .rsp           (rsp),
      .rsp_ready     (rsp_ready),
      .init_done     (init_done),
      .af_wren       (af_wren),
      .af            (af),
      .af_afull      (af_afull),
      .wdf_wren      (wdf_wren),
      .wdf           (wdf),
      .wdf_afull     (wdf_afull),
      .rd_data_valid (rd_data_valid),
      .rd_data       (rd_data)
   );

   app_mem_model u_model (
      .clk           (clk),
      .reset         (reset),
      .af_wren       (af_wren),
      .af            (af),
      .wdf_wren      (wdf_wren),
      .wdf           (wdf),
      .init_done     (init_done),
      .af_afull      (af_afull),
      .wdf_afull     (wdf_afull),
      .rd_data_valid (rd_data_valid),
      .rd_data       (rd_data)
   );

   ////////////////////
   // helpers
   ////////////////////

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic take_bit(output logic b);
      b = lfsr[0];
      lfsr = lfsr_step(lfsr);
   endtask

   task automatic take_line_bits(output logic [line_w-1:0] v);
      for (int k = 0; k < line_w; k++) begin
         take_bit(v[k]);
      end
   endtask

   task automatic note_error(input string what);
      $display("Error: %s", what);
      errors++;
   endtask

   task automatic check_line(input string name, input line_rsp_t got, input line_rsp_t exp,
                             input int idx);
      if (got !== exp) begin
         $display("Fail %s: got %h expected %h", name, got, exp);
         errors++;
         entry_bad[idx] = 1'b1;
      end
   endtask

   task automatic check_app_cmd(input string name, input app_cmd_t got, input app_cmd_t exp,
                                input int idx);
      if (got !== exp) begin
         $display("Fail %s: got %h expected %h", name, got, exp);
         errors++;
         entry_bad[idx] = 1'b1;
      end
   endtask

   task automatic check_wdf(input string name, input app_wdf_t got, input app_wdf_t exp,
                            input int idx);
      if (got !== exp) begin
         $display("Fail %s: got %h expected %h", name, got, exp);
         errors++;
         entry_bad[idx] = 1'b1;
      end
   endtask

   task automatic finish_test(input int idx, input string kind);
      done_count++;
      $display("test %0d %s addr %h: %s", idx, kind, stim_table[idx].addr,
               entry_bad[idx] ? "FAILED" : "ok");
   endtask

   // present one entry and wait for the cache handshake.
   task automatic drive_request(input int i);
      app_cmd_t  cmd;
      app_wdf_t  beat;
      line_rsp_t line;
      @(negedge clk);
      req_valid  = 1'b1;
      req.write  = stim_table[i].write;
      req.addr   = stim_table[i].addr;
      req.data   = line_data[i];
      // controller address is the line address times four.
      cmd.cmd    = stim_table[i].write ? app_write : app_read;
      cmd.addr   = app_addr_w'({stim_table[i].addr, 2'b00});
      cmd_q.push_back(cmd);
      cmd_idx_q.push_back(i);
      if (stim_table[i].write) begin
         beat.data = line_data[i][beat_w-1:0];
         beat_q.push_back(beat);
         beat.data = line_data[i][line_w-1:beat_w];
         beat_q.push_back(beat);
         beat_idx_q.push_back(i);
         beat_idx_q.push_back(i);
         pred[stim_table[i].addr] = line_data[i];
      end else begin
         line.data = pred[stim_table[i].addr];
         line_q.push_back(line);
         line_idx_q.push_back(i);
      end
      @(posedge clk);
      while (!req_ready) begin
         @(posedge clk);
      end
   endtask

   ////////////////////
   // clock and stimulus
   ////////////////////

   always #20 clk = ~clk;

   // random back-pressure on responses.
   always @(negedge clk) begin
      logic b;
      take_bit(b);
      rsp_ready = b;
   end

   initial begin
      logic [line_w-1:0] bits;
      int                passed;
      reset     = 1'b1;
      req_valid = 1'b0;
      req       = '0;
      rsp_ready = 1'b0;
      // expand every line before the clock starts.
      for (int i = 0; i < n_tests; i++) begin
         take_line_bits(bits);
         line_data[i] = bits ^ {8{stim_table[i].seed}};
      end
      repeat (16) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      if (req_ready || af_wren || wdf_wren || rsp_valid) begin
         note_error("outputs not low after reset");
      end
      // first entry waits out the init stretch.
      for (int i = 0; i < n_tests; i++) begin
         drive_request(i);
      end
      @(negedge clk);
      req_valid = 1'b0;
      while (done_count < n_tests) begin
         @(posedge clk);
      end
      passed = 0;
      for (int i = 0; i < n_tests; i++) begin
         passed += entry_bad[i] ? 0 : 1;
      end
      $display("%0d of %0d tests passed, %0d errors", passed, n_tests, errors);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

   ////////////////////
   // monitor
   ////////////////////

   always @(posedge clk) begin
      int idx;
      if (!reset) begin
         if (!init_done && req_ready) begin
            note_error("req_ready high before init_done");
         end
         if ((af_wren || wdf_wren) && (af_afull || wdf_afull)) begin
            note_error("fifo written while almost full");
         end
         if (af_wren) begin
            if (cmd_q.size() == 0) begin
               note_error("af command with nothing expected");
            end else begin
               idx = cmd_idx_q.pop_front();
               check_app_cmd("af", af, cmd_q.pop_front(), idx);
               if (af.cmd == app_read && line_out) begin
                  note_error("read issued before the previous line was taken");
               end
               line_out = line_out || (af.cmd == app_read);
            end
         end
         if (wdf_wren) begin
            if (beat_q.size() == 0) begin
               note_error("wdf beat with nothing expected");
            end else begin
               idx = beat_idx_q.pop_front();
               check_wdf("wdf", wdf, beat_q.pop_front(), idx);
               // last beat of this entry ends the write.
               if (beat_idx_q.size() == 0 || beat_idx_q[0] != idx) begin
                  finish_test(idx, "write");
               end
            end
         end
         // a stalled line must hold still.
         if (rsp_held && !rsp_valid) begin
            note_error("rsp_valid dropped before the line was taken");
         end
         if (rsp_held && line_idx_q.size() > 0) begin
            check_line("rsp", rsp, rsp_prev, line_idx_q[0]);
         end
         if (rsp_valid && rsp_ready) begin
            if (line_q.size() == 0) begin
               note_error("response with no read outstanding");
            end else begin
               idx = line_idx_q.pop_front();
               check_line("rsp", rsp, line_q.pop_front(), idx);
               finish_test(idx, "read");
            end
            line_out = 1'b0;
         end
         rsp_held = rsp_valid && !rsp_ready;
         rsp_prev = rsp;
      end
   end

   ////////////////////
   // timeout
   ////////////////////

   always @(posedge clk) begin
      cycle++;
      if (cycle >= cycle_limit) begin
         $display("timeout: run did not finish within %0d cycles", cycle_limit);
         $display("Something failed");
         $finish;
      end
   end

endmodule

// ==== files.f ====
hw/mem_line_pkg.sv
hw/line_req_intake.sv
hw/beat_sequencer.sv
hw/read_line_assembler.sv
hw/mem_line_port.sv
dv/app_mem_model.sv
dv/tb_mem_line_port.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_mem_line_port
FILELIST  = files.f
OBJ_DIR   = obj_dir

SOURCES   = $(shell cat $(FILELIST))
BIN       = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf $(OBJ_DIR)
